/* logic/hello_pkg.sv */
// Hello-world register map, bus widths and shared types
`default_nettype none

package hello_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_RESP_W = 2;
  localparam int VLED_W      = 16;
  localparam int CNT_W       = 16;
  localparam int TICK_W      = 8;

  // Bus and payload types
  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_RESP_W-1:0] axil_resp_t;
  typedef logic [VLED_W-1:0]      vled_t;
  typedef logic [CNT_W-1:0]       cnt_t;
  typedef logic [TICK_W-1:0]      tick_t;

  // Only response ever returned
  localparam axil_resp_t RESP_OKAY = 2'b00;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam axil_addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam axil_addr_t VLED_ADDR        = 32'h0000_0504;
  localparam axil_addr_t CNT_CTRL_ADDR    = 32'h0000_0510;
  localparam axil_addr_t TICK_VALUE_ADDR  = 32'h0000_0514;
  localparam axil_addr_t LOAD_VALUE_ADDR  = 32'h0000_0518;
  localparam axil_addr_t WATERMARK_ADDR   = 32'h0000_051C;
  localparam axil_addr_t CNT_STATUS_ADDR  = 32'h0000_0520;

  // Read value for anything off the map
  localparam axil_data_t UNIMPLEMENTED_VALUE = 32'hDEAF_BEEF;

  // Control word fields, enable and one-shot stored, clear and load pulsed
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_CLEAR_BIT   = 2;
  localparam int CTRL_LOAD_BIT    = 3;

  // Status word, flag sits just above the count
  localparam int STATUS_FLAG_BIT = 16;

  // One-shot saturation point
  localparam cnt_t CNT_MAX = 16'hFFFF;

endpackage

`default_nettype wire

/* logic/axil_reg_slice.sv */
// AXI-Lite register slice, one buffer stage on each of the five channels
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slice
  import hello_pkg::*;
(
  input  wire logic       clk_main_a0,
  input  wire logic       rst_main_n_sync,
  // Slave side, host facing
  input  wire logic       s_awvalid,
  input  wire axil_addr_t s_awaddr,
  output logic            s_awready,
  input  wire logic       s_wvalid,
  input  wire axil_data_t s_wdata,
  output logic            s_wready,
  output logic            s_bvalid,
  output axil_resp_t      s_bresp,
  input  wire logic       s_bready,
  input  wire logic       s_arvalid,
  input  wire axil_addr_t s_araddr,
  output logic            s_arready,
  output logic            s_rvalid,
  output axil_data_t      s_rdata,
  output axil_resp_t      s_rresp,
  input  wire logic       s_rready,
  // Master side, register block facing
  output logic            m_awvalid,
  output axil_addr_t      m_awaddr,
  input  wire logic       m_awready,
  output logic            m_wvalid,
  output axil_data_t      m_wdata,
  input  wire logic       m_wready,
  input  wire logic       m_bvalid,
  input  wire axil_resp_t m_bresp,
  output logic            m_bready,
  output logic            m_arvalid,
  output axil_addr_t      m_araddr,
  input  wire logic       m_arready,
  input  wire logic       m_rvalid,
  input  wire axil_data_t m_rdata,
  input  wire axil_resp_t m_rresp,
  output logic            m_rready
);

  // Stage occupancy, one flag per channel
  logic aw_full;
  logic w_full;
  logic b_full;
  logic ar_full;
  logic r_full;

  // Held payloads
  axil_addr_t aw_addr_q;
  axil_data_t w_data_q;
  axil_resp_t b_resp_q;
  axil_addr_t ar_addr_q;
  axil_data_t r_data_q;
  axil_resp_t r_resp_q;

  // ------------------------------
  // Ready and valid
  // ------------------------------
  // Accept when empty or when the held beat drains this cycle
  assign s_awready = !aw_full || m_awready;
  assign s_wready  = !w_full || m_wready;
  assign m_bready  = !b_full || s_bready;
  assign s_arready = !ar_full || m_arready;
  assign m_rready  = !r_full || s_rready;

  assign m_awvalid = aw_full;
  assign m_wvalid  = w_full;
  assign s_bvalid  = b_full;
  assign m_arvalid = ar_full;
  assign s_rvalid  = r_full;

  assign m_awaddr = aw_addr_q;
  assign m_wdata  = w_data_q;
  assign s_bresp  = b_resp_q;
  assign m_araddr = ar_addr_q;
  assign s_rdata  = r_data_q;
  assign s_rresp  = r_resp_q;

  // ------------------------------
  // Occupancy flags
  // ------------------------------
  // New beat wins over drain, so a back-to-back beat keeps the stage full
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      b_full  <= 1'b0;
      ar_full <= 1'b0;
      r_full  <= 1'b0;
    end else begin
      if (s_awvalid && s_awready) begin
        aw_full <= 1'b1;
      end else if (m_awready) begin
        aw_full <= 1'b0;
      end
      if (s_wvalid && s_wready) begin
        w_full <= 1'b1;
      end else if (m_wready) begin
        w_full <= 1'b0;
      end
      // Response channels run the other way
      if (m_bvalid && m_bready) begin
        b_full <= 1'b1;
      end else if (s_bready) begin
        b_full <= 1'b0;
      end
      if (s_arvalid && s_arready) begin
        ar_full <= 1'b1;
      end else if (m_arready) begin
        ar_full <= 1'b0;
      end
      if (m_rvalid && m_rready) begin
        r_full <= 1'b1;
      end else if (s_rready) begin
        r_full <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Payload registers
  // ------------------------------
  // Loaded only on an accepted beat, stable while stalled
  always_ff @(posedge clk_main_a0) begin
    if (s_awvalid && s_awready) begin
      aw_addr_q <= s_awaddr;
    end
    if (s_wvalid && s_wready) begin
      w_data_q <= s_wdata;
    end
    if (m_bvalid && m_bready) begin
      b_resp_q <= m_bresp;
    end
    if (s_arvalid && s_arready) begin
      ar_addr_q <= s_araddr;
    end
    if (m_rvalid && m_rready) begin
      r_data_q <= m_rdata;
      r_resp_q <= m_rresp;
    end
  end

endmodule

`default_nettype wire

/* logic/ocl_reg_block.sv */
// AXI-Lite register block with hello-world, virtual LED and counter controls
`timescale 1ns/1ps
`default_nettype none

module ocl_reg_block
  import hello_pkg::*;
(
  input  wire logic       clk_main_a0,
  input  wire logic       rst_main_n_sync,
  // AXI-Lite slave, from the slice master side
  input  wire logic       awvalid,
  input  wire axil_addr_t awaddr,
  output logic            awready,
  input  wire logic       wvalid,
  input  wire axil_data_t wdata,
  output logic            wready,
  output logic            bvalid,
  output axil_resp_t      bresp,
  input  wire logic       bready,
  input  wire logic       arvalid,
  input  wire axil_addr_t araddr,
  output logic            arready,
  output logic            rvalid,
  output axil_data_t      rdata,
  output axil_resp_t      rresp,
  input  wire logic       rready,
  // Virtual switches and LEDs
  input  wire vled_t      vdip,
  output vled_t           vled,
  // Counter side
  input  wire cnt_t       count,
  input  wire logic       count_ge_watermark,
  output logic            cnt_enable,
  output logic            cnt_oneshot,
  output logic            cnt_clear,
  output logic            cnt_load,
  output tick_t           tick_value,
  output cnt_t            load_value,
  output cnt_t            watermark
);

  // Read sequencing, address latch then decode then respond
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_SAMPLE,
    RD_RESP
  } rd_state_t;

  logic       wr_active;
  axil_addr_t wr_addr_q;
  rd_state_t  rd_state;
  axil_addr_t rd_addr_q;
  axil_data_t rd_mux;

  axil_data_t hello_world_q;
  axil_data_t hello_swapped;
  vled_t      vled_shadow;
  vled_t      vdip_q;

  // ------------------------------
  // Write path
  // ------------------------------
  assign awready = !wr_active;
  assign wready  = wr_active && wvalid;
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      // Busy from address accept until the response leaves
      if (wr_active && bvalid && bready) begin
        wr_active <= 1'b0;
      end else if (awvalid && awready) begin
        wr_active <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (wready) begin
        bvalid <= 1'b1;
      end
    end
  end

  // Address kept for decode on the data beat
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  // Register updates on the w transfer, unmapped writes fall through
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
      cnt_enable    <= 1'b0;
      cnt_oneshot   <= 1'b0;
      cnt_clear     <= 1'b0;
      cnt_load      <= 1'b0;
      tick_value    <= '0;
      load_value    <= '0;
      watermark     <= '0;
    end else begin
      // Pulses last one cycle by default
      cnt_clear <= 1'b0;
      cnt_load  <= 1'b0;
      if (wready) begin
        case (wr_addr_q)
          HELLO_WORLD_ADDR: hello_world_q <= wdata;
          CNT_CTRL_ADDR: begin
            cnt_enable  <= wdata[CTRL_ENABLE_BIT];
            cnt_oneshot <= wdata[CTRL_ONESHOT_BIT];
            cnt_clear   <= wdata[CTRL_CLEAR_BIT];
            cnt_load    <= wdata[CTRL_LOAD_BIT];
          end
          TICK_VALUE_ADDR: tick_value <= wdata[TICK_W-1:0];
          LOAD_VALUE_ADDR: load_value <= wdata[CNT_W-1:0];
          WATERMARK_ADDR:  watermark  <= wdata[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_RESP);
  assign rresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE:   if (arvalid) rd_state <= RD_ADDR;
        RD_ADDR:   rd_state <= RD_SAMPLE;
        RD_SAMPLE: rd_state <= RD_RESP;
        RD_RESP:   if (rready) rd_state <= RD_IDLE;
        default:   rd_state <= RD_IDLE;
      endcase
    end
  end

  // Latch address, then sample the data as rvalid rises
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
    if (rd_state == RD_SAMPLE) begin
      rdata <= rd_mux;
    end
  end

  // Readback decode
  always_comb begin
    rd_mux = UNIMPLEMENTED_VALUE;
    case (rd_addr_q)
      HELLO_WORLD_ADDR: rd_mux = hello_swapped;
      VLED_ADDR:        rd_mux = {16'h0000, vled_shadow};
      CNT_CTRL_ADDR: begin
        rd_mux = '0;
        rd_mux[CTRL_ENABLE_BIT]  = cnt_enable;
        rd_mux[CTRL_ONESHOT_BIT] = cnt_oneshot;
      end
      TICK_VALUE_ADDR: rd_mux = {24'h00_0000, tick_value};
      LOAD_VALUE_ADDR: rd_mux = {16'h0000, load_value};
      WATERMARK_ADDR:  rd_mux = {16'h0000, watermark};
      CNT_STATUS_ADDR: begin
        rd_mux = {16'h0000, count};
        rd_mux[STATUS_FLAG_BIT] = count_ge_watermark;
      end
      default: ;
    endcase
  end

  // Hello-world reads back with byte order reversed
  assign hello_swapped = {hello_world_q[7:0], hello_world_q[15:8],
                          hello_world_q[23:16], hello_world_q[31:24]};

  // ------------------------------
  // Virtual LEDs
  // ------------------------------
  // Shadow trails hello-world by a cycle, LED output one more
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_shadow <= '0;
      vdip_q      <= '0;
      vled        <= '0;
    end else begin
      vled_shadow <= hello_world_q[VLED_W-1:0];
      vdip_q      <= vdip;
      // Switch off means LED off
      vled        <= vled_shadow & vdip_q;
    end
  end

endmodule

`default_nettype wire

/* logic/tick_counter.sv */
// Prescaled event counter with load, clear, one-shot and watermark flag
`timescale 1ns/1ps
`default_nettype none

module tick_counter
  import hello_pkg::*;
(
  input  wire logic  clk_main_a0,
  input  wire logic  rst_main_n_sync,
  input  wire logic  cnt_enable,
  input  wire logic  cnt_oneshot,
  input  wire logic  cnt_clear,
  input  wire logic  cnt_load,
  input  wire tick_t tick_value,
  input  wire cnt_t  load_value,
  input  wire cnt_t  watermark,
  output cnt_t       count,
  output logic       count_ge_watermark
);

  tick_t tick_cnt;
  logic  tick;

  // Wrap point of the prescaler
  // Compare with >= so a smaller tick_value cannot strand the prescaler
  assign tick = cnt_enable && (tick_cnt >= tick_value);

  // ------------------------------
  // Prescaler
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || cnt_clear) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else if (cnt_enable) begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Main count
  // ------------------------------
  // Clear beats load, load beats counting
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || cnt_clear) begin
      count <= '0;
    end else if (cnt_load) begin
      count <= load_value;
    end else if (tick && !(cnt_oneshot && (count == CNT_MAX))) begin
      // One-shot holds at the top, otherwise wraps
      count <= count + 1'b1;
    end
  end

  // Registered watermark compare
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count_ge_watermark <= 1'b0;
    end else begin
      count_ge_watermark <= (count >= watermark);
    end
  end

endmodule

`default_nettype wire

/* logic/cl_hello_top.sv */
// Hello-world top level, reset sync, AXI-Lite slice, registers and counter
`timescale 1ns/1ps
`default_nettype none

module cl_hello_top
  import hello_pkg::*;
(
  input  wire logic       clk_main_a0,
  input  wire logic       rst_main_n,
  // Host AXI-Lite port
  input  wire logic       awvalid,
  input  wire axil_addr_t awaddr,
  output logic            awready,
  input  wire logic       wvalid,
  input  wire axil_data_t wdata,
  output logic            wready,
  output logic            bvalid,
  output axil_resp_t      bresp,
  input  wire logic       bready,
  input  wire logic       arvalid,
  input  wire axil_addr_t araddr,
  output logic            arready,
  output logic            rvalid,
  output axil_data_t      rdata,
  output axil_resp_t      rresp,
  input  wire logic       rready,
  // Virtual switches and LEDs
  input  wire vled_t      vdip,
  output vled_t           vled
);

  logic rst_pre_n;
  logic rst_main_n_sync;

  // Slice to register block
  logic       m_awvalid;
  axil_addr_t m_awaddr;
  logic       m_awready;
  logic       m_wvalid;
  axil_data_t m_wdata;
  logic       m_wready;
  logic       m_bvalid;
  axil_resp_t m_bresp;
  logic       m_bready;
  logic       m_arvalid;
  axil_addr_t m_araddr;
  logic       m_arready;
  logic       m_rvalid;
  axil_data_t m_rdata;
  axil_resp_t m_rresp;
  logic       m_rready;

  // Register block to counter
  logic  cnt_enable;
  logic  cnt_oneshot;
  logic  cnt_clear;
  logic  cnt_load;
  tick_t tick_value;
  cnt_t  load_value;
  cnt_t  watermark;
  cnt_t  count;
  logic  count_ge_watermark;

  // ------------------------------
  // Reset synchronizer
  // ------------------------------
  // Asserts at once, releases after two clock edges
  always_ff @(posedge clk_main_a0 or negedge rst_main_n) begin
    if (!rst_main_n) begin
      rst_pre_n       <= 1'b0;
      rst_main_n_sync <= 1'b0;
    end else begin
      rst_pre_n       <= 1'b1;
      rst_main_n_sync <= rst_pre_n;
    end
  end

  // Timing stage on the host port
  axil_reg_slice i_slice (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .s_awvalid       (awvalid),
    .s_awaddr        (awaddr),
    .s_awready       (awready),
    .s_wvalid        (wvalid),
    .s_wdata         (wdata),
    .s_wready        (wready),
    .s_bvalid        (bvalid),
    .s_bresp         (bresp),
    .s_bready        (bready),
    .s_arvalid       (arvalid),
    .s_araddr        (araddr),
    .s_arready       (arready),
    .s_rvalid        (rvalid),
    .s_rdata         (rdata),
    .s_rresp         (rresp),
    .s_rready        (rready),
    .m_awvalid       (m_awvalid),
    .m_awaddr        (m_awaddr),
    .m_awready       (m_awready),
    .m_wvalid        (m_wvalid),
    .m_wdata         (m_wdata),
    .m_wready        (m_wready),
    .m_bvalid        (m_bvalid),
    .m_bresp         (m_bresp),
    .m_bready        (m_bready),
    .m_arvalid       (m_arvalid),
    .m_araddr        (m_araddr),
    .m_arready       (m_arready),
    .m_rvalid        (m_rvalid),
    .m_rdata         (m_rdata),
    .m_rresp         (m_rresp),
    .m_rready        (m_rready)
  );

  // Register map and LED logic
  ocl_reg_block i_regs (
    .clk_main_a0        (clk_main_a0),
    .rst_main_n_sync    (rst_main_n_sync),
    .awvalid            (m_awvalid),
    .awaddr             (m_awaddr),
    .awready            (m_awready),
    .wvalid             (m_wvalid),
    .wdata              (m_wdata),
    .wready             (m_wready),
    .bvalid             (m_bvalid),
    .bresp              (m_bresp),
    .bready             (m_bready),
    .arvalid            (m_arvalid),
    .araddr             (m_araddr),
    .arready            (m_arready),
    .rvalid             (m_rvalid),
    .rdata              (m_rdata),
    .rresp              (m_rresp),
    .rready             (m_rready),
    .vdip               (vdip),
    .vled               (vled),
    .count              (count),
    .count_ge_watermark (count_ge_watermark),
    .cnt_enable         (cnt_enable),
    .cnt_oneshot        (cnt_oneshot),
    .cnt_clear          (cnt_clear),
    .cnt_load           (cnt_load),
    .tick_value         (tick_value),
    .load_value         (load_value),
    .watermark          (watermark)
  );

  // Event counter under register control
  tick_counter i_counter (
    .clk_main_a0        (clk_main_a0),
    .rst_main_n_sync    (rst_main_n_sync),
    .cnt_enable         (cnt_enable),
    .cnt_oneshot        (cnt_oneshot),
    .cnt_clear          (cnt_clear),
    .cnt_load           (cnt_load),
    .tick_value         (tick_value),
    .load_value         (load_value),
    .watermark          (watermark),
    .count              (count),
    .count_ge_watermark (count_ge_watermark)
  );

endmodule

`default_nettype wire

/* dv/tb_hello.sv */
// Table-driven testbench for the hello-world top over its AXI-Lite host port
`timescale 1ns/1ps
`default_nettype none

module tb_hello
  import hello_pkg::*;
();

  // Longest wait on any handshake, in cycles
  localparam int WAIT_LIMIT = 200;

  // Table operations
  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_DIP,
    OP_IDLE,
    OP_LED
  } op_t;

  // Handshake flags the waits can watch
  typedef enum logic [2:0] {
    CH_AWREADY,
    CH_WREADY,
    CH_BVALID,
    CH_ARREADY,
    CH_RVALID
  } chan_t;

  typedef struct packed {
    op_t        op;
    axil_addr_t addr;
    axil_data_t data;
    axil_data_t exp;
  } step_t;

  // DUT inputs
  logic       clk_main_a0;
  logic       rst_main_n;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       wvalid;
  axil_data_t wdata;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       rready;
  vled_t      vdip;

  // DUT outputs
  logic       awready;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  vled_t      vled;

  step_t       steps[$];
  int          mismatches;
  int          timeouts;
  logic [31:0] lfsr_state;

  cl_hello_top i_dut (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .awready     (awready),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .bready      (bready),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rready      (rready),
    .vdip        (vdip),
    .vled        (vled)
  );

  // 40 ns period
  always #20 clk_main_a0 = ~clk_main_a0;

  // ------------------------------
  // Helpers
  // ------------------------------
  // Galois LFSR, one step per bit drawn
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hA300_0000;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  function automatic logic flag_of(input chan_t ch);
    case (ch)
      CH_AWREADY: return awready;
      CH_WREADY:  return wready;
      CH_BVALID:  return bvalid;
      CH_ARREADY: return arready;
      default:    return rvalid;
    endcase
  endfunction

  // Polls on falling edges, where DUT outputs are settled
  task automatic wait_for_flag(input chan_t ch, output logic ok);
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (!flag_of(ch) && n < WAIT_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    ok = flag_of(ch);
    if (!ok) begin
      timeouts++;
      $display("Timeout at %0t: %s stayed low for %0d cycles", $time, ch.name(), WAIT_LIMIT);
    end
  endtask

  // ------------------------------
  // AXI-Lite master
  // ------------------------------
  // Address beat, then data beat, then response under back-pressure
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    logic       ok;
    int         delay;
    axil_resp_t resp_seen;
    @(posedge clk_main_a0);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wait_for_flag(CH_AWREADY, ok);
    // Transfer happens on this edge
    @(posedge clk_main_a0);
    awvalid <= 1'b0;
    if (!ok) return;
    wvalid <= 1'b1;
    wdata  <= data;
    wait_for_flag(CH_WREADY, ok);
    @(posedge clk_main_a0);
    wvalid <= 1'b0;
    if (!ok) return;
    wait_for_flag(CH_BVALID, ok);
    if (!ok) return;
    resp_seen = bresp;
    draw_bits(3, delay);
    // Response must stay put while bready is low
    for (int i = 0; i < delay; i++) begin
      @(negedge clk_main_a0);
      assert (bvalid && bresp == resp_seen) else begin
        report_mismatch($sformatf("b channel changed while stalled, write to 0x%08h", addr));
      end
    end
    @(posedge clk_main_a0);
    bready <= 1'b1;
    @(posedge clk_main_a0);
    bready <= 1'b0;
    assert (resp_seen == RESP_OKAY) else begin
      report_mismatch($sformatf("bresp %0d for write to 0x%08h, expected OKAY", resp_seen, addr));
    end
  endtask

  task automatic axil_read(input axil_addr_t addr, input axil_data_t exp);
    logic       ok;
    int         delay;
    axil_data_t data_seen;
    axil_resp_t resp_seen;
    @(posedge clk_main_a0);
    arvalid <= 1'b1;
    araddr  <= addr;
    wait_for_flag(CH_ARREADY, ok);
    @(posedge clk_main_a0);
    arvalid <= 1'b0;
    if (!ok) return;
    wait_for_flag(CH_RVALID, ok);
    if (!ok) return;
    data_seen = rdata;
    resp_seen = rresp;
    draw_bits(3, delay);
    // Data and valid held until rready
    for (int i = 0; i < delay; i++) begin
      @(negedge clk_main_a0);
      assert (rvalid && rdata == data_seen && rresp == resp_seen) else begin
        report_mismatch($sformatf("r channel changed while stalled, read of 0x%08h", addr));
      end
    end
    @(posedge clk_main_a0);
    rready <= 1'b1;
    @(posedge clk_main_a0);
    rready <= 1'b0;
    assert (data_seen == exp) else begin
      report_mismatch($sformatf("read of 0x%08h returned 0x%08h, expected 0x%08h",
                                addr, data_seen, exp));
    end
    assert (resp_seen == RESP_OKAY) else begin
      report_mismatch($sformatf("rresp %0d for read of 0x%08h, expected OKAY", resp_seen, addr));
    end
  endtask

  // ------------------------------
  // Test table
  // ------------------------------
  task automatic add_step(input op_t op, input axil_addr_t addr,
                          input axil_data_t data, input axil_data_t exp);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  task automatic build_table();
    // Hello-world reads back byte-swapped
    add_step(OP_WRITE, HELLO_WORLD_ADDR, 32'h1234_5678, '0);
    add_step(OP_READ,  HELLO_WORLD_ADDR, '0, 32'h7856_3412);
    // Shadow of the low half, then off-map reads and writes
    add_step(OP_READ,  VLED_ADDR,        '0, 32'h0000_5678);
    add_step(OP_READ,  32'h0000_0600,    '0, 32'hDEAF_BEEF);
    add_step(OP_WRITE, 32'h0000_0600,    32'hFFFF_FFFF, '0);
    add_step(OP_READ,  HELLO_WORLD_ADDR, '0, 32'h7856_3412);
    // All switches off, LEDs dark
    add_step(OP_LED,   '0, '0, 32'h0000_0000);
    // LEDs follow hello-world low half ANDed with the switches
    add_step(OP_DIP,   '0, 32'h0000_0F0F, '0);
    add_step(OP_WRITE, HELLO_WORLD_ADDR, 32'hCAFE_F00D, '0);
    add_step(OP_IDLE,  '0, 32'd3, '0);
    add_step(OP_LED,   '0, '0, 32'h0000_000D);
    add_step(OP_READ,  HELLO_WORLD_ADDR, '0, 32'h0DF0_FECA);
    add_step(OP_READ,  VLED_ADDR,        '0, 32'h0000_F00D);
    add_step(OP_DIP,   '0, 32'h0000_FF00, '0);
    add_step(OP_IDLE,  '0, 32'd3, '0);
    add_step(OP_LED,   '0, '0, 32'h0000_F000);
    add_step(OP_DIP,   '0, 32'h0000_FFFF, '0);
    add_step(OP_IDLE,  '0, 32'd3, '0);
    add_step(OP_LED,   '0, '0, 32'h0000_F00D);
    // Counter load with enable off, flag set since 0xABCD >= 0x8000
    add_step(OP_WRITE, WATERMARK_ADDR,   32'h0000_8000, '0);
    add_step(OP_READ,  WATERMARK_ADDR,   '0, 32'h0000_8000);
    add_step(OP_WRITE, LOAD_VALUE_ADDR,  32'h0000_ABCD, '0);
    add_step(OP_WRITE, CNT_CTRL_ADDR,    32'h0000_0008, '0);
    add_step(OP_READ,  CNT_STATUS_ADDR,  '0, 32'h0001_ABCD);
    // Clear pulse, zero is below the watermark
    add_step(OP_WRITE, CNT_CTRL_ADDR,    32'h0000_0004, '0);
    add_step(OP_READ,  CNT_STATUS_ADDR,  '0, 32'h0000_0000);
    // One-shot run from 0xFFF0 saturates at the top
    add_step(OP_WRITE, TICK_VALUE_ADDR,  32'h0000_0000, '0);
    add_step(OP_READ,  TICK_VALUE_ADDR,  '0, 32'h0000_0000);
    add_step(OP_WRITE, LOAD_VALUE_ADDR,  32'h0000_FFF0, '0);
    add_step(OP_WRITE, CNT_CTRL_ADDR,    32'h0000_0008, '0);
    add_step(OP_WRITE, CNT_CTRL_ADDR,    32'h0000_0003, '0);
    add_step(OP_READ,  CNT_CTRL_ADDR,    '0, 32'h0000_0003);
    add_step(OP_IDLE,  '0, 32'd64, '0);
    add_step(OP_READ,  CNT_STATUS_ADDR,  '0, 32'h0001_FFFF);
    // Back-to-back reads after stalled responses
    add_step(OP_READ,  HELLO_WORLD_ADDR, '0, 32'h0DF0_FECA);
    add_step(OP_READ,  CNT_STATUS_ADDR,  '0, 32'h0001_FFFF);
  endtask

  task automatic apply_step(input step_t s);
    case (s.op)
      OP_WRITE: axil_write(s.addr, s.data);
      OP_READ:  axil_read(s.addr, s.exp);
      OP_DIP: begin
        @(posedge clk_main_a0);
        vdip <= s.data[VLED_W-1:0];
      end
      OP_IDLE:  repeat (s.data) @(posedge clk_main_a0);
      default: begin
        @(negedge clk_main_a0);
        assert (vled == s.exp[VLED_W-1:0]) else begin
          report_mismatch($sformatf("vled 0x%04h, expected 0x%04h", vled, s.exp[VLED_W-1:0]));
        end
      end
    endcase
  endtask

  // Idle bus right after reset
  task automatic check_after_reset();
    @(negedge clk_main_a0);
    assert (!bvalid && !rvalid) else begin
      report_mismatch("response valid high after reset");
    end
    assert (awready && wready && arready) else begin
      report_mismatch("slice not ready after reset");
    end
    assert (vled == '0) else begin
      report_mismatch($sformatf("vled 0x%04h after reset, expected 0", vled));
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    clk_main_a0 = 1'b0;
    rst_main_n  = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    vdip        = '0;
    lfsr_state  = 32'h77ff;
    mismatches  = 0;
    timeouts    = 0;
    build_table();
    repeat (3) @(posedge clk_main_a0);
    rst_main_n <= 1'b1;
    // Synchronizer releases two edges later
    repeat (3) @(posedge clk_main_a0);
    check_after_reset();
    // Stop applying steps once a handshake has hung
    foreach (steps[i]) begin
      if (timeouts == 0) begin
        apply_step(steps[i]);
      end
    end
    $display("Error counts: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/hello_pkg.sv
logic/axil_reg_slice.sv
logic/ocl_reg_block.sv
logic/tick_counter.sv
logic/cl_hello_top.sv
dv/tb_hello.sv

/* Makefile */
TOP := tb_hello

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard logic/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o V$(TOP)

# Pass only if the pass line shows up in the simulation output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
